/* mpfifo_pkg.sv */
/*
  Shared sizes and types for the multi-lane FIFO.
  Lane counts, bank count and depths are fixed here and used by every RTL file
  through scoped names.
*/

package mpfifo_pkg;

  // ==================================================
  // Lane and storage sizes
  // ==================================================

  localparam int WR_LANES = 4;
  localparam int RD_LANES = 4;

  // One bank per lane on the wider side
  localparam int BANKS = (WR_LANES > RD_LANES) ? WR_LANES : RD_LANES;

  // Total entries, must be a multiple of BANKS
  localparam int FIFO_DEPTH = 16;
  localparam int BANK_DEPTH = FIFO_DEPTH / BANKS;

  localparam int DATA_W = 32;

  // Derived widths
  localparam int BANK_IDX_W  = $clog2(BANKS);
  localparam int LANE_CNT_W  = $clog2(BANKS) + 1;
  localparam int BANK_ADDR_W = $clog2(BANK_DEPTH);

  // ==================================================
  // Vector types
  // ==================================================

  // One payload word
  typedef logic [DATA_W-1:0] data_t;

  // Bank or lane number, wraps modulo BANKS
  typedef logic [BANK_IDX_W-1:0] bank_idx_t;

  // Number of enabled lanes, 0 up to BANKS
  typedef logic [LANE_CNT_W-1:0] lane_cnt_t;

  // Slot address inside one bank
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

/* bank_fifo_if.sv */
`timescale 1ns/10ps

/*
  Connection between the lane steering logic and one storage bank.
  The steering side pushes and pops, the bank side reports its head word
  and its empty and full state.
*/

interface bank_fifo_if;

  logic              push;
  logic              pop;
  mpfifo_pkg::data_t wdata;
  mpfifo_pkg::data_t rdata;
  logic              empty;
  logic              full;

  // Steering block side
  modport steer (
    output push, pop, wdata,
    input  rdata, empty, full
  );

  // Storage bank side
  modport bank (
    input  push, pop, wdata,
    output rdata, empty, full
  );

endinterface

/* bank_fifo.sv */
`timescale 1ns/10ps

/*
  One storage bank of the multi-lane FIFO.
  Small synchronous FIFO whose oldest word is always shown on rdata,
  so the steering block can read it without popping first.
*/

module bank_fifo (
  input logic        clk,
  input logic        arst_n_i,
  input logic        flush_i,
  bank_fifo_if.bank  bank
);

  mpfifo_pkg::data_t    mem [mpfifo_pkg::BANK_DEPTH];

  mpfifo_pkg::bank_addr_t wr_addr;
  mpfifo_pkg::bank_addr_t rd_addr;
  logic                   wr_wrap;
  logic                   rd_wrap;

  logic do_push;
  logic do_pop;

  // ==================================================
  // Status and head word
  // ==================================================

  // Same slot, the wrap flags tell empty from full
  assign bank.empty = (wr_addr == rd_addr) && (wr_wrap == rd_wrap);
  assign bank.full  = (wr_addr == rd_addr) && (wr_wrap != rd_wrap);
  assign bank.rdata = mem[rd_addr];

  // Requests against a full or empty bank are dropped
  assign do_push = bank.push & ~bank.full & ~flush_i;
  assign do_pop  = bank.pop & ~bank.empty & ~flush_i;

  // ==================================================
  // Storage and pointers
  // ==================================================

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_addr] <= bank.wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_addr <= '0;
      wr_wrap <= 1'b0;
    end else if (flush_i) begin
      wr_addr <= '0;
      wr_wrap <= 1'b0;
    end else if (do_push) begin
      if (wr_addr == mpfifo_pkg::bank_addr_t'(mpfifo_pkg::BANK_DEPTH - 1)) begin
        wr_addr <= '0;
        wr_wrap <= ~wr_wrap;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // Head advances at the pop edge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_addr <= '0;
      rd_wrap <= 1'b0;
    end else if (flush_i) begin
      rd_addr <= '0;
      rd_wrap <= 1'b0;
    end else if (do_pop) begin
      if (rd_addr == mpfifo_pkg::bank_addr_t'(mpfifo_pkg::BANK_DEPTH - 1)) begin
        rd_addr <= '0;
        rd_wrap <= ~rd_wrap;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

endmodule

/* multi_port_fifo.sv */
`timescale 1ns/10ps

/*
  Lane steering for the multi-lane FIFO.
  Deals accepted words round-robin over the banks and gathers the oldest
  unread words back onto the read lanes. Enabled write lanes and ready
  read lanes must each form a run starting at lane 0.
*/

module multi_port_fifo (
  input  logic                                          clk,
  input  logic                                          arst_n_i,
  input  logic                                          flush_i,

  input  logic [mpfifo_pkg::WR_LANES-1:0]               write_valid_i,
  output logic                                          write_ready_o,
  input  mpfifo_pkg::data_t [mpfifo_pkg::WR_LANES-1:0]  write_data_i,

  output logic [mpfifo_pkg::RD_LANES-1:0]               read_valid_o,
  input  logic [mpfifo_pkg::RD_LANES-1:0]               read_ready_i,
  output mpfifo_pkg::data_t [mpfifo_pkg::RD_LANES-1:0]  read_data_o,

  bank_fifo_if.steer                                    banks [mpfifo_pkg::BANKS]
);

  mpfifo_pkg::lane_cnt_t wr_cnt;
  mpfifo_pkg::lane_cnt_t rd_cnt;
  mpfifo_pkg::lane_cnt_t full_cnt;

  logic write_accept;
  logic read_accept;

  // Per bank rotating indices
  mpfifo_pkg::bank_idx_t [mpfifo_pkg::BANKS-1:0] wr_idx;
  mpfifo_pkg::bank_idx_t [mpfifo_pkg::BANKS-1:0] rd_idx;

  // Per read lane, the bank holding that lane's word
  mpfifo_pkg::bank_idx_t [mpfifo_pkg::RD_LANES-1:0] out_idx;

  // Bank status gathered from the interfaces
  logic [mpfifo_pkg::BANKS-1:0]                  bank_full;
  logic [mpfifo_pkg::BANKS-1:0]                  bank_empty;
  mpfifo_pkg::data_t [mpfifo_pkg::BANKS-1:0]     bank_rdata;

  // ==================================================
  // Lane counts and write acceptance
  // ==================================================

  always_comb begin
    wr_cnt = '0;
    for (int i = 0; i < mpfifo_pkg::WR_LANES; i++) begin
      wr_cnt = wr_cnt + mpfifo_pkg::lane_cnt_t'(write_valid_i[i]);
    end

    rd_cnt = '0;
    for (int i = 0; i < mpfifo_pkg::RD_LANES; i++) begin
      rd_cnt = rd_cnt + mpfifo_pkg::lane_cnt_t'(read_ready_i[i]);
    end

    full_cnt = '0;
    for (int i = 0; i < mpfifo_pkg::BANKS; i++) begin
      full_cnt = full_cnt + mpfifo_pkg::lane_cnt_t'(bank_full[i]);
    end
  end

  // Room for a full-width write needs enough non-full banks
  assign write_ready_o = full_cnt <=
                         mpfifo_pkg::lane_cnt_t'(mpfifo_pkg::BANKS - mpfifo_pkg::WR_LANES);

  assign write_accept = write_ready_o && (wr_cnt != '0);
  assign read_accept  = (rd_cnt != '0);

  // ==================================================
  // Bank side control
  // ==================================================

  for (genvar b = 0; b < mpfifo_pkg::BANKS; b++) begin : gen_bank_ctrl

    assign bank_full[b]  = banks[b].full;
    assign bank_empty[b] = banks[b].empty;
    assign bank_rdata[b] = banks[b].rdata;

    // Index below the count means this bank takes part this cycle
    assign banks[b].push  = write_ready_o &&
                            (mpfifo_pkg::lane_cnt_t'(wr_idx[b]) < wr_cnt);
    assign banks[b].pop   = mpfifo_pkg::lane_cnt_t'(rd_idx[b]) < rd_cnt;
    assign banks[b].wdata = write_data_i[wr_idx[b]];

    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_idx[b] <= mpfifo_pkg::bank_idx_t'(b);
      end else if (flush_i) begin
        wr_idx[b] <= mpfifo_pkg::bank_idx_t'(b);
      end else if (write_accept) begin
        wr_idx[b] <= wr_idx[b] - mpfifo_pkg::bank_idx_t'(wr_cnt);
      end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rd_idx[b] <= mpfifo_pkg::bank_idx_t'(b);
      end else if (flush_i) begin
        rd_idx[b] <= mpfifo_pkg::bank_idx_t'(b);
      end else if (read_accept) begin
        rd_idx[b] <= rd_idx[b] - mpfifo_pkg::bank_idx_t'(rd_cnt);
      end
    end

  end

  // ==================================================
  // Read lane output
  // ==================================================

  for (genvar j = 0; j < mpfifo_pkg::RD_LANES; j++) begin : gen_read_lane

    // Lane j points at the bank of the j-th oldest word
    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        out_idx[j] <= mpfifo_pkg::bank_idx_t'(j);
      end else if (flush_i) begin
        out_idx[j] <= mpfifo_pkg::bank_idx_t'(j);
      end else if (read_accept) begin
        out_idx[j] <= out_idx[j] + mpfifo_pkg::bank_idx_t'(rd_cnt);
      end
    end

    assign read_data_o[j]  = bank_rdata[out_idx[j]];
    assign read_valid_o[j] = ~bank_empty[out_idx[j]];

  end

endmodule

/* mpfifo_top.sv */
`timescale 1ns/10ps

/*
  Top level of the multi-lane FIFO with flat ports.
  Lane data is packed lane 0 in the low bits. Holds the steering block
  and one bank FIFO per bank.
*/

module mpfifo_top (
  input  logic                                              clk,
  input  logic                                              arst_n_i,
  input  logic                                              flush_i,

  input  logic [mpfifo_pkg::WR_LANES-1:0]                   write_valid_i,
  output logic                                              write_ready_o,
  input  logic [mpfifo_pkg::WR_LANES*mpfifo_pkg::DATA_W-1:0] write_data_i,

  output logic [mpfifo_pkg::RD_LANES-1:0]                   read_valid_o,
  input  logic [mpfifo_pkg::RD_LANES-1:0]                   read_ready_i,
  output logic [mpfifo_pkg::RD_LANES*mpfifo_pkg::DATA_W-1:0] read_data_o
);

  mpfifo_pkg::data_t [mpfifo_pkg::WR_LANES-1:0] wr_data;
  mpfifo_pkg::data_t [mpfifo_pkg::RD_LANES-1:0] rd_data;

  bank_fifo_if bank_if [mpfifo_pkg::BANKS] ();

  // Flat port vectors to lane words
  for (genvar l = 0; l < mpfifo_pkg::WR_LANES; l++) begin : gen_wr_unpack
    assign wr_data[l] = write_data_i[l*mpfifo_pkg::DATA_W +: mpfifo_pkg::DATA_W];
  end

  for (genvar l = 0; l < mpfifo_pkg::RD_LANES; l++) begin : gen_rd_pack
    assign read_data_o[l*mpfifo_pkg::DATA_W +: mpfifo_pkg::DATA_W] = rd_data[l];
  end

  multi_port_fifo i_steer (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .write_valid_i (write_valid_i),
    .write_ready_o (write_ready_o),
    .write_data_i  (wr_data),
    .read_valid_o  (read_valid_o),
    .read_ready_i  (read_ready_i),
    .read_data_o   (rd_data),
    .banks         (bank_if)
  );

  for (genvar b = 0; b < mpfifo_pkg::BANKS; b++) begin : gen_bank
    bank_fifo i_bank (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .flush_i  (flush_i),
      .bank     (bank_if[b])
    );
  end

endmodule

/* mpfifo_assert.sv */
`timescale 1ns/10ps

/*
  Lane protocol checks on the ports of the multi-lane FIFO top level.
  Bound into every mpfifo_top instance.
*/

module mpfifo_assert (
  input logic                            clk,
  input logic                            arst_n_i,
  input logic                            flush_i,
  input logic [mpfifo_pkg::WR_LANES-1:0] write_valid_i,
  input logic [mpfifo_pkg::RD_LANES-1:0] read_valid_o,
  input logic [mpfifo_pkg::RD_LANES-1:0] read_ready_i
);

  // Lanes 0 to k-1 set and nothing above them
  function automatic logic is_prefix(logic [mpfifo_pkg::BANKS-1:0] v);
    for (int i = 1; i < mpfifo_pkg::BANKS; i++) begin
      if (v[i] && !v[i-1]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  a_write_prefix: assert property (@(posedge clk) disable iff (!arst_n_i)
    is_prefix(write_valid_i))
    else $error("write_valid_i is not a run starting at lane 0");

  a_ready_prefix: assert property (@(posedge clk) disable iff (!arst_n_i)
    is_prefix(read_ready_i))
    else $error("read_ready_i is not a run starting at lane 0");

  a_ready_on_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
    (read_ready_i & ~read_valid_o) == '0)
    else $error("read_ready_i set on a lane without read_valid_o");

  a_valid_prefix: assert property (@(posedge clk) disable iff (!arst_n_i)
    is_prefix(read_valid_o))
    else $error("read_valid_o is not a run starting at lane 0");

  // Flush empties every bank at the edge
  a_flush_empties: assert property (@(posedge clk) disable iff (!arst_n_i)
    flush_i |=> (read_valid_o == '0))
    else $error("read_valid_o not cleared after flush");

endmodule

bind mpfifo_top mpfifo_assert i_assert (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .flush_i       (flush_i),
  .write_valid_i (write_valid_i),
  .read_valid_o  (read_valid_o),
  .read_ready_i  (read_ready_i)
);

/* tb_mpfifo.sv */
`timescale 1ns/10ps

/*
  Testbench for the multi-lane FIFO top level.
  Replays the per-cycle lines of mpfifo_testdata.txt, keeps a queue model
  of the FIFO contents and compares the DUT outputs before every edge.
*/

module tb_mpfifo;

  logic                                               clk;
  logic                                               arst_n_i;
  logic                                               flush_i;
  logic [mpfifo_pkg::WR_LANES-1:0]                    write_valid_i;
  logic                                               write_ready_o;
  logic [mpfifo_pkg::WR_LANES*mpfifo_pkg::DATA_W-1:0] write_data_i;
  logic [mpfifo_pkg::RD_LANES-1:0]                    read_valid_o;
  logic [mpfifo_pkg::RD_LANES-1:0]                    read_ready_i;
  logic [mpfifo_pkg::RD_LANES*mpfifo_pkg::DATA_W-1:0] read_data_o;

  // Stimulus lines from the data file
  int line_test[$];
  int line_flush[$];
  int line_wcnt[$];
  int line_rcnt[$];
  logic [mpfifo_pkg::WR_LANES*mpfifo_pkg::DATA_W-1:0] line_words[$];

  // Reference model, words in sequence order plus per-bank occupancy
  mpfifo_pkg::data_t model_q[$];
  int bank_occ [mpfifo_pkg::BANKS];
  int wr_seq;
  int rd_seq;

  int cycle_cnt = 0;
  int cycle_limit = 0;
  int cur_test;
  int test_errors = 0;
  int total_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  mpfifo_top i_dut (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .write_valid_i (write_valid_i),
    .write_ready_o (write_ready_o),
    .write_data_i  (write_data_i),
    .read_valid_o  (read_valid_o),
    .read_ready_i  (read_ready_i),
    .read_data_o   (read_data_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("ERROR: timeout, the run did not end within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ==================================================
  // Reference model
  // ==================================================

  function automatic logic model_ready();
    int full_banks;
    full_banks = 0;
    for (int b = 0; b < mpfifo_pkg::BANKS; b++) begin
      if (bank_occ[b] >= mpfifo_pkg::BANK_DEPTH) begin
        full_banks++;
      end
    end
    return full_banks <= (mpfifo_pkg::BANKS - mpfifo_pkg::WR_LANES);
  endfunction

  // Lane i is valid when the bank of the i-th oldest sequence number holds a word
  function automatic logic [mpfifo_pkg::RD_LANES-1:0] model_valid();
    logic [mpfifo_pkg::RD_LANES-1:0] mask;
    mask = '0;
    for (int i = 0; i < mpfifo_pkg::RD_LANES; i++) begin
      mask[i] = bank_occ[(rd_seq + i) % mpfifo_pkg::BANKS] > 0;
    end
    return mask;
  endfunction

  function automatic logic [mpfifo_pkg::BANKS-1:0] lane_mask(int n);
    logic [mpfifo_pkg::BANKS-1:0] mask;
    for (int i = 0; i < mpfifo_pkg::BANKS; i++) begin
      mask[i] = i < n;
    end
    return mask;
  endfunction

  task automatic clear_model();
    model_q.delete();
    for (int b = 0; b < mpfifo_pkg::BANKS; b++) begin
      bank_occ[b] = 0;
    end
    wr_seq = 0;
    rd_seq = 0;
  endtask

  // ==================================================
  // File, stimulus and checks
  // ==================================================

  task automatic read_file(output bit ok);
    int fd;
    int t;
    int f;
    int w;
    int r;
    string text;
    mpfifo_pkg::data_t d [4];
    fd = $fopen("mpfifo_testdata.txt", "r");
    if (fd != 0) begin
      while ($fgets(text, fd) != 0) begin
        // Comment and blank lines do not scan as eight fields
        if ($sscanf(text, "%d %d %d %d %h %h %h %h", t, f, w, r,
                    d[0], d[1], d[2], d[3]) == 8) begin
          line_test.push_back(t);
          line_flush.push_back(f);
          line_wcnt.push_back(w);
          line_rcnt.push_back(r);
          line_words.push_back({d[3], d[2], d[1], d[0]});
        end
      end
      $fclose(fd);
    end
    ok = line_test.size() > 0;
  endtask

  task automatic check_outputs();
    logic                            exp_ready;
    logic [mpfifo_pkg::RD_LANES-1:0] exp_valid;
    mpfifo_pkg::data_t               got;
    exp_ready = model_ready();
    exp_valid = model_valid();
    if (write_ready_o !== exp_ready) begin
      $display("FAIL test %0d: write_ready_o = %h, expected %h",
               cur_test, write_ready_o, exp_ready);
      test_errors++;
    end
    if (read_valid_o !== exp_valid) begin
      $display("FAIL test %0d: read_valid_o = %h, expected %h",
               cur_test, read_valid_o, exp_valid);
      test_errors++;
    end
    for (int i = 0; i < mpfifo_pkg::RD_LANES; i++) begin
      got = read_data_o[i*mpfifo_pkg::DATA_W +: mpfifo_pkg::DATA_W];
      if (exp_valid[i] && i < model_q.size() && got !== model_q[i]) begin
        $display("FAIL test %0d: read_data_o lane %0d = %h, expected %h",
                 cur_test, i, got, model_q[i]);
        test_errors++;
      end
    end
  endtask

  // Drives one line and moves the model past the coming edge
  task automatic apply_line(int n);
    int                              rcnt;
    logic                            ready;
    logic [mpfifo_pkg::RD_LANES-1:0] valid;
    ready = model_ready();
    valid = model_valid();
    rcnt  = 0;
    while (rcnt < line_rcnt[n] && rcnt < mpfifo_pkg::RD_LANES && valid[rcnt]) begin
      rcnt++;
    end
    flush_i       = line_flush[n] != 0;
    write_valid_i = lane_mask(line_wcnt[n]);
    write_data_i  = line_words[n];
    read_ready_i  = lane_mask(rcnt);
    if (line_flush[n] != 0) begin
      clear_model();
    end else begin
      for (int i = 0; i < rcnt; i++) begin
        void'(model_q.pop_front());
        bank_occ[rd_seq % mpfifo_pkg::BANKS]--;
        rd_seq++;
      end
      for (int i = 0; i < line_wcnt[n] && ready; i++) begin
        model_q.push_back(line_words[n][i*mpfifo_pkg::DATA_W +: mpfifo_pkg::DATA_W]);
        bank_occ[wr_seq % mpfifo_pkg::BANKS]++;
        wr_seq++;
      end
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d finished, no errors", cur_test);
    end else begin
      $display("test %0d finished, %0d errors", cur_test, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    bit file_ok;
    arst_n_i      = 1'b0;
    flush_i       = 1'b0;
    write_valid_i = '0;
    write_data_i  = '0;
    read_ready_i  = '0;
    clear_model();
    read_file(file_ok);
    if (!file_ok) begin
      $display("ERROR: no stimulus lines could be read from mpfifo_testdata.txt");
      $display("*** FAILED ***");
      $finish;
    end else begin
      // Data lines, 16 reset cycles and 50 spare cycles
      cycle_limit = line_test.size() + 16 + 50;
      repeat (16) @(negedge clk);
      arst_n_i = 1'b1;
      cur_test = line_test[0];
      for (int n = 0; n < line_test.size(); n++) begin
        @(negedge clk);
        check_outputs();
        if (line_test[n] != cur_test) begin
          finish_test();
          cur_test = line_test[n];
        end
        apply_line(n);
      end
      @(negedge clk);
      check_outputs();
      finish_test();
      flush_i       = 1'b0;
      write_valid_i = '0;
      read_ready_i  = '0;
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

/* mpfifo_testdata.txt */
# Multi-lane FIFO stimulus, one line per clock cycle
# Columns: test flush write_lanes read_request lane0 lane1 lane2 lane3 (data in hex)
# Test 1, idle after reset
1 0 0 0 10000011 10000012 10000013 10000014
1 0 0 0 10000021 10000022 10000023 10000024
# Test 2, one word per cycle on lane 0
2 0 1 1 20000011 20000012 20000013 20000014
2 0 1 1 20000021 20000022 20000023 20000024
2 0 1 1 20000031 20000032 20000033 20000034
2 0 1 1 20000041 20000042 20000043 20000044
2 0 1 1 20000051 20000052 20000053 20000054
2 0 1 1 20000061 20000062 20000063 20000064
2 0 0 1 20000071 20000072 20000073 20000074
2 0 0 1 20000081 20000082 20000083 20000084
# Test 3, uneven write and read lane counts across bank wrap
3 0 3 0 30000011 30000012 30000013 30000014
3 0 2 1 30000021 30000022 30000023 30000024
3 0 4 2 30000031 30000032 30000033 30000034
3 0 1 3 30000041 30000042 30000043 30000044
3 0 3 4 30000051 30000052 30000053 30000054
3 0 0 4 30000061 30000062 30000063 30000064
3 0 2 2 30000071 30000072 30000073 30000074
3 0 0 1 30000081 30000082 30000083 30000084
3 0 0 4 30000091 30000092 30000093 30000094
# Test 4, fill until a bank is full, offered words are dropped
4 0 4 0 40000011 40000012 40000013 40000014
4 0 4 0 40000021 40000022 40000023 40000024
4 0 4 0 40000031 40000032 40000033 40000034
4 0 4 0 40000041 40000042 40000043 40000044
4 0 4 0 40000051 40000052 40000053 40000054
4 0 2 0 40000061 40000062 40000063 40000064
4 0 4 1 40000071 40000072 40000073 40000074
4 0 4 4 40000081 40000082 40000083 40000084
4 0 4 0 40000091 40000092 40000093 40000094
4 0 2 0 400000a1 400000a2 400000a3 400000a4
4 0 0 4 400000b1 400000b2 400000b3 400000b4
4 0 0 4 400000c1 400000c2 400000c3 400000c4
4 0 0 4 400000d1 400000d2 400000d3 400000d4
4 0 0 4 400000e1 400000e2 400000e3 400000e4
# Test 5, flush with a write and a read in the same cycle
5 0 4 0 50000011 50000012 50000013 50000014
5 0 3 0 50000021 50000022 50000023 50000024
5 1 4 4 50000031 50000032 50000033 50000034
5 0 2 2 50000041 50000042 50000043 50000044
5 0 0 2 50000051 50000052 50000053 50000054
5 0 0 2 50000061 50000062 50000063 50000064
# Test 6, full width read and write together
6 0 4 0 60000011 60000012 60000013 60000014
6 0 4 0 60000021 60000022 60000023 60000024
6 0 4 4 60000031 60000032 60000033 60000034
6 0 4 4 60000041 60000042 60000043 60000044
6 0 4 4 60000051 60000052 60000053 60000054
6 0 4 4 60000061 60000062 60000063 60000064
6 0 4 4 60000071 60000072 60000073 60000074
6 0 0 4 60000081 60000082 60000083 60000084
6 0 0 4 60000091 60000092 60000093 60000094

/* files.f */
mpfifo_pkg.sv
bank_fifo_if.sv
bank_fifo.sv
multi_port_fifo.sv
mpfifo_top.sv
mpfifo_assert.sv
tb_mpfifo.sv

/* run.sh */
#!/bin/sh
# Build the multi-lane FIFO testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mpfifo -f files.f -o tb_mpfifo

out=$(./obj_dir/tb_mpfifo || true)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1
